// File: Bender.yml
package:
  name: ooo_issue

sources:
  - files:
      - common/core_types_pkg.sv
      - common/alu_ops_pkg.sv
      - issue_queue/issue_select.sv
      - issue_queue/issue_queue.sv
      - rtl/operand_fetch.sv
      - rtl/alu_stage.sv
      - rtl/ooo_issue_top.sv
  - target: test
    files:
      - sim/ooo_issue_properties.sv
      - sim/tb_ooo_issue.sv

// File: all.f
common/core_types_pkg.sv
common/alu_ops_pkg.sv
issue_queue/issue_select.sv
issue_queue/issue_queue.sv
rtl/operand_fetch.sv
rtl/alu_stage.sv
rtl/ooo_issue_top.sv
sim/ooo_issue_properties.sv
sim/tb_ooo_issue.sv

// File: common/alu_ops_pkg.sv
`default_nettype none

package alu_ops_pkg;

  localparam int ALU_CMD_W = 4;

  typedef logic [ALU_CMD_W-1:0] alu_cmd_t;

  localparam alu_cmd_t CMD_ADD  = 4'h0;
  localparam alu_cmd_t CMD_SUB  = 4'h1;
  localparam alu_cmd_t CMD_AND  = 4'h2;
  localparam alu_cmd_t CMD_OR   = 4'h3;
  localparam alu_cmd_t CMD_XOR  = 4'h4;
  localparam alu_cmd_t CMD_SLL  = 4'h5;
  localparam alu_cmd_t CMD_SLT  = 4'h6;
  // reserves the destination only, result comes back on the memory bus
  localparam alu_cmd_t CMD_LOAD = 4'hf;

endpackage

`default_nettype wire

// File: common/core_types_pkg.sv
`default_nettype none

package core_types_pkg;

  localparam int DATA_W     = 32;
  localparam int PREG_W     = 6;
  localparam int PREG_COUNT = 64;
  localparam int AGE_W      = 4;
  localparam int IQ_SIZE    = 8;
  localparam int IQ_IDX_W   = 3;

  // operand and result word
  typedef logic [DATA_W-1:0]   data_t;
  // physical register number, already renamed
  typedef logic [PREG_W-1:0]   preg_t;
  // dispatch order tag, wraps around
  typedef logic [AGE_W-1:0]    age_t;
  typedef logic [IQ_IDX_W-1:0] iq_idx_t;

endpackage

`default_nettype wire

// File: issue_queue/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
  parameter int IQ_SIZE = core_types_pkg::IQ_SIZE
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fetch_valid,
  input  alu_ops_pkg::alu_cmd_t fetch_cmd,
  input  core_types_pkg::data_t fetch_op1,
  input  core_types_pkg::data_t fetch_op2,
  input  logic                  fetch_op1_valid,
  input  logic                  fetch_op2_valid,
  input  core_types_pkg::preg_t fetch_dest,
  input  logic                  alu_wb_valid,
  input  core_types_pkg::preg_t alu_wb_tag,
  input  core_types_pkg::data_t alu_wb_data,
  input  logic                  mem_wb_valid,
  input  core_types_pkg::preg_t mem_wb_tag,
  input  core_types_pkg::data_t mem_wb_data,
  output logic                  full,
  output logic                  issue_valid,
  output alu_ops_pkg::alu_cmd_t issue_cmd,
  output core_types_pkg::data_t issue_op1,
  output core_types_pkg::data_t issue_op2,
  output core_types_pkg::preg_t issue_dest
);
  import core_types_pkg::*;
  import alu_ops_pkg::*;

  logic [IQ_SIZE-1:0] entry_valid;
  logic [IQ_SIZE-1:0] entry_op1_valid;
  logic [IQ_SIZE-1:0] entry_op2_valid;
  logic [IQ_SIZE-1:0] entry_ready;
  age_t               entry_age [IQ_SIZE];
  alu_cmd_t           entry_cmd [IQ_SIZE];
  data_t              entry_op1 [IQ_SIZE];
  data_t              entry_op2 [IQ_SIZE];
  preg_t              entry_dest [IQ_SIZE];
  age_t               age_cnt;

  data_t              nxt_op1 [IQ_SIZE];
  data_t              nxt_op2 [IQ_SIZE];
  logic [IQ_SIZE-1:0] nxt_op1_valid;
  logic [IQ_SIZE-1:0] nxt_op2_valid;
  data_t              in_op1;
  data_t              in_op2;
  logic               in_op1_valid;
  logic               in_op2_valid;

  // heap ordered, node n has children 2n+1 and 2n+2
  logic               free_v [2*IQ_SIZE-1];
  iq_idx_t            free_idx [2*IQ_SIZE-1];
  logic               sel_valid;
  iq_idx_t            sel_idx;
  logic               write_en;

  // pending operand holds its register number in the low bits
  function automatic logic [DATA_W:0] wake(
    input data_t op,
    input logic  op_valid,
    input logic  a_valid,
    input preg_t a_tag,
    input data_t a_data,
    input logic  m_valid,
    input preg_t m_tag,
    input data_t m_data
  );
    logic [DATA_W:0] res;
    res = {op_valid, op};
    if (!op_valid) begin
      if (a_valid && op[PREG_W-1:0] == a_tag) begin
        res = {1'b1, a_data};
      end else if (m_valid && op[PREG_W-1:0] == m_tag) begin
        res = {1'b1, m_data};
      end
    end
    return res;
  endfunction

  always_comb begin
    {in_op1_valid, in_op1} = wake(fetch_op1, fetch_op1_valid, alu_wb_valid, alu_wb_tag,
                                  alu_wb_data, mem_wb_valid, mem_wb_tag, mem_wb_data);
    {in_op2_valid, in_op2} = wake(fetch_op2, fetch_op2_valid, alu_wb_valid, alu_wb_tag,
                                  alu_wb_data, mem_wb_valid, mem_wb_tag, mem_wb_data);
    for (int i = 0; i < IQ_SIZE; i++) begin
      {nxt_op1_valid[i], nxt_op1[i]} = wake(entry_op1[i], entry_op1_valid[i],
                                            alu_wb_valid, alu_wb_tag, alu_wb_data,
                                            mem_wb_valid, mem_wb_tag, mem_wb_data);
      {nxt_op2_valid[i], nxt_op2[i]} = wake(entry_op2[i], entry_op2_valid[i],
                                            alu_wb_valid, alu_wb_tag, alu_wb_data,
                                            mem_wb_valid, mem_wb_tag, mem_wb_data);
    end
  end

  // lowest free slot wins
  always_comb begin
    for (int i = 0; i < IQ_SIZE; i++) begin
      free_v[IQ_SIZE-1+i]   = !entry_valid[i];
      free_idx[IQ_SIZE-1+i] = iq_idx_t'(i);
    end
    for (int n = IQ_SIZE - 2; n >= 0; n--) begin
      free_v[n]   = free_v[2*n+1] || free_v[2*n+2];
      free_idx[n] = free_v[2*n+1] ? free_idx[2*n+1] : free_idx[2*n+2];
    end
  end

  // the fetch register counts as taken so an accepted dispatch has a slot
  always_comb begin
    int occupied;
    occupied = int'(fetch_valid);
    for (int i = 0; i < IQ_SIZE; i++) begin
      occupied = occupied + int'(entry_valid[i]);
    end
    full = (occupied >= IQ_SIZE);
  end

  assign write_en    = fetch_valid && free_v[0];
  assign entry_ready = entry_valid & entry_op1_valid & entry_op2_valid;

  issue_select #(
    .IQ_SIZE(IQ_SIZE)
  ) u_select (
    .entry_ready(entry_ready),
    .entry_age  (entry_age),
    .sel_valid  (sel_valid),
    .sel_idx    (sel_idx)
  );

  assign issue_valid = sel_valid;
  assign issue_cmd   = entry_cmd[sel_idx];
  assign issue_op1   = entry_op1[sel_idx];
  assign issue_op2   = entry_op2[sel_idx];
  assign issue_dest  = entry_dest[sel_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      entry_valid <= '0;
      age_cnt     <= '0;
    end else begin
      // issued slot and written slot never coincide
      if (issue_valid) begin
        entry_valid[sel_idx] <= 1'b0;
      end
      if (write_en) begin
        entry_valid[free_idx[0]] <= 1'b1;
        age_cnt                  <= age_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    entry_op1       <= nxt_op1;
    entry_op2       <= nxt_op2;
    entry_op1_valid <= nxt_op1_valid;
    entry_op2_valid <= nxt_op2_valid;
    if (write_en) begin
      entry_age[free_idx[0]]       <= age_cnt;
      entry_cmd[free_idx[0]]       <= fetch_cmd;
      entry_dest[free_idx[0]]      <= fetch_dest;
      entry_op1[free_idx[0]]       <= in_op1;
      entry_op2[free_idx[0]]       <= in_op2;
      entry_op1_valid[free_idx[0]] <= in_op1_valid;
      entry_op2_valid[free_idx[0]] <= in_op2_valid;
    end
  end

endmodule

`default_nettype wire

// File: issue_queue/issue_select.sv
`timescale 1ns/1ps
`default_nettype none

module issue_select #(
  parameter int IQ_SIZE = core_types_pkg::IQ_SIZE
) (
  input  logic [IQ_SIZE-1:0]    entry_ready,
  input  core_types_pkg::age_t  entry_age [IQ_SIZE],
  output logic                  sel_valid,
  output core_types_pkg::iq_idx_t sel_idx
);
  import core_types_pkg::*;

  logic    node_v [2*IQ_SIZE-1];
  age_t    node_age [2*IQ_SIZE-1];
  iq_idx_t node_idx [2*IQ_SIZE-1];

  // top bit is the lap, low bits order within a lap
  // across a lap change the larger low part was dispatched first
  function automatic logic is_older(input age_t a, input age_t b);
    logic res;
    if (a[AGE_W-1] == b[AGE_W-1]) begin
      res = a[AGE_W-2:0] < b[AGE_W-2:0];
    end else begin
      res = a[AGE_W-2:0] > b[AGE_W-2:0];
    end
    return res;
  endfunction

  always_comb begin
    logic take_r;
    for (int i = 0; i < IQ_SIZE; i++) begin
      node_v[IQ_SIZE-1+i]   = entry_ready[i];
      node_age[IQ_SIZE-1+i] = entry_age[i];
      node_idx[IQ_SIZE-1+i] = iq_idx_t'(i);
    end
    // pairwise, leaves upward to the root
    for (int n = IQ_SIZE - 2; n >= 0; n--) begin
      take_r = node_v[2*n+2] &&
               (!node_v[2*n+1] || is_older(node_age[2*n+2], node_age[2*n+1]));
      node_v[n]   = node_v[2*n+1] || node_v[2*n+2];
      node_age[n] = take_r ? node_age[2*n+2] : node_age[2*n+1];
      node_idx[n] = take_r ? node_idx[2*n+2] : node_idx[2*n+1];
    end
  end

  assign sel_valid = node_v[0];
  assign sel_idx   = node_idx[0];

endmodule

`default_nettype wire

// File: rtl/alu_stage.sv
`timescale 1ns/1ps
`default_nettype none

module alu_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue_valid,
  input  alu_ops_pkg::alu_cmd_t issue_cmd,
  input  core_types_pkg::data_t issue_op1,
  input  core_types_pkg::data_t issue_op2,
  input  core_types_pkg::preg_t issue_dest,
  output logic                  result_valid,
  output core_types_pkg::preg_t result_tag,
  output core_types_pkg::data_t result_data
);
  import core_types_pkg::*;
  import alu_ops_pkg::*;

  data_t alu_out;

  always_comb begin
    case (issue_cmd)
      CMD_ADD: alu_out = issue_op1 + issue_op2;
      CMD_SUB: alu_out = issue_op1 - issue_op2;
      CMD_AND: alu_out = issue_op1 & issue_op2;
      CMD_OR:  alu_out = issue_op1 | issue_op2;
      CMD_XOR: alu_out = issue_op1 ^ issue_op2;
      // shift amount from op2[4:0] only
      CMD_SLL: alu_out = issue_op1 << issue_op2[4:0];
      CMD_SLT: alu_out = data_t'($signed(issue_op1) < $signed(issue_op2));
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      result_tag  <= issue_dest;
      result_data <= alu_out;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ooo_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_issue_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  dispatch_valid,
  input  alu_ops_pkg::alu_cmd_t dispatch_cmd,
  input  core_types_pkg::preg_t dispatch_src1,
  input  core_types_pkg::preg_t dispatch_src2,
  input  core_types_pkg::data_t dispatch_imm,
  input  logic                  dispatch_use_imm,
  input  core_types_pkg::preg_t dispatch_dest,
  input  logic                  mem_result_valid,
  input  core_types_pkg::preg_t mem_result_tag,
  input  core_types_pkg::data_t mem_result_data,
  output logic                  full,
  output logic                  result_valid,
  output core_types_pkg::preg_t result_tag,
  output core_types_pkg::data_t result_data
);
  import core_types_pkg::*;
  import alu_ops_pkg::*;

  logic     fetch_valid;
  alu_cmd_t fetch_cmd;
  data_t    fetch_op1;
  data_t    fetch_op2;
  logic     fetch_op1_valid;
  logic     fetch_op2_valid;
  preg_t    fetch_dest;

  logic     issue_valid;
  alu_cmd_t issue_cmd;
  data_t    issue_op1;
  data_t    issue_op2;
  preg_t    issue_dest;

  operand_fetch u_fetch (
    .clk             (clk),
    .rst             (rst),
    .dispatch_valid  (dispatch_valid),
    .dispatch_cmd    (dispatch_cmd),
    .dispatch_src1   (dispatch_src1),
    .dispatch_src2   (dispatch_src2),
    .dispatch_dest   (dispatch_dest),
    .dispatch_imm    (dispatch_imm),
    .dispatch_use_imm(dispatch_use_imm),
    .alu_wb_valid    (result_valid),
    .alu_wb_tag      (result_tag),
    .alu_wb_data     (result_data),
    .mem_wb_valid    (mem_result_valid),
    .mem_wb_tag      (mem_result_tag),
    .mem_wb_data     (mem_result_data),
    .fetch_valid     (fetch_valid),
    .fetch_cmd       (fetch_cmd),
    .fetch_op1       (fetch_op1),
    .fetch_op2       (fetch_op2),
    .fetch_op1_valid (fetch_op1_valid),
    .fetch_op2_valid (fetch_op2_valid),
    .fetch_dest      (fetch_dest)
  );

  issue_queue u_iq (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid    (fetch_valid),
    .fetch_cmd      (fetch_cmd),
    .fetch_op1      (fetch_op1),
    .fetch_op2      (fetch_op2),
    .fetch_op1_valid(fetch_op1_valid),
    .fetch_op2_valid(fetch_op2_valid),
    .fetch_dest     (fetch_dest),
    .alu_wb_valid   (result_valid),
    .alu_wb_tag     (result_tag),
    .alu_wb_data    (result_data),
    .mem_wb_valid   (mem_result_valid),
    .mem_wb_tag     (mem_result_tag),
    .mem_wb_data    (mem_result_data),
    .full           (full),
    .issue_valid    (issue_valid),
    .issue_cmd      (issue_cmd),
    .issue_op1      (issue_op1),
    .issue_op2      (issue_op2),
    .issue_dest     (issue_dest)
  );

  // result bus loops back as the wakeup broadcast
  alu_stage u_alu (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_cmd   (issue_cmd),
    .issue_op1   (issue_op1),
    .issue_op2   (issue_op2),
    .issue_dest  (issue_dest),
    .result_valid(result_valid),
    .result_tag  (result_tag),
    .result_data (result_data)
  );

endmodule

`default_nettype wire

// File: rtl/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  dispatch_valid,
  input  alu_ops_pkg::alu_cmd_t dispatch_cmd,
  input  core_types_pkg::preg_t dispatch_src1,
  input  core_types_pkg::preg_t dispatch_src2,
  input  core_types_pkg::preg_t dispatch_dest,
  input  core_types_pkg::data_t dispatch_imm,
  input  logic                  dispatch_use_imm,
  input  logic                  alu_wb_valid,
  input  core_types_pkg::preg_t alu_wb_tag,
  input  core_types_pkg::data_t alu_wb_data,
  input  logic                  mem_wb_valid,
  input  core_types_pkg::preg_t mem_wb_tag,
  input  core_types_pkg::data_t mem_wb_data,
  output logic                  fetch_valid,
  output alu_ops_pkg::alu_cmd_t fetch_cmd,
  output core_types_pkg::data_t fetch_op1,
  output core_types_pkg::data_t fetch_op2,
  output logic                  fetch_op1_valid,
  output logic                  fetch_op2_valid,
  output core_types_pkg::preg_t fetch_dest
);
  import core_types_pkg::*;
  import alu_ops_pkg::*;

  data_t                 rf_value [PREG_COUNT];
  logic [PREG_COUNT-1:0] rf_ready;

  data_t src1_data;
  data_t src2_data;
  logic  src1_valid;
  logic  src2_valid;

  // register value, then same-cycle broadcast, else the pending tag
  function automatic logic [DATA_W:0] read_src(
    input preg_t src,
    input logic  ready,
    input data_t value,
    input logic  a_valid,
    input preg_t a_tag,
    input data_t a_data,
    input logic  m_valid,
    input preg_t m_tag,
    input data_t m_data
  );
    logic [DATA_W:0] res;
    if (ready) begin
      res = {1'b1, value};
    end else if (a_valid && a_tag == src) begin
      res = {1'b1, a_data};
    end else if (m_valid && m_tag == src) begin
      res = {1'b1, m_data};
    end else begin
      res = {1'b0, data_t'(src)};
    end
    return res;
  endfunction

  always_comb begin
    {src1_valid, src1_data} = read_src(dispatch_src1, rf_ready[dispatch_src1],
                                       rf_value[dispatch_src1],
                                       alu_wb_valid, alu_wb_tag, alu_wb_data,
                                       mem_wb_valid, mem_wb_tag, mem_wb_data);
    {src2_valid, src2_data} = read_src(dispatch_src2, rf_ready[dispatch_src2],
                                       rf_value[dispatch_src2],
                                       alu_wb_valid, alu_wb_tag, alu_wb_data,
                                       mem_wb_valid, mem_wb_tag, mem_wb_data);
    if (dispatch_use_imm) begin
      src2_valid = 1'b1;
      src2_data  = dispatch_imm;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rf_ready <= '1;
      for (int i = 0; i < PREG_COUNT; i++) begin
        rf_value[i] <= '0;
      end
    end else begin
      if (alu_wb_valid) begin
        rf_value[alu_wb_tag] <= alu_wb_data;
        rf_ready[alu_wb_tag] <= 1'b1;
      end
      if (mem_wb_valid) begin
        rf_value[mem_wb_tag] <= mem_wb_data;
        rf_ready[mem_wb_tag] <= 1'b1;
      end
      // a new producer wins over any writeback to the same register
      if (dispatch_valid) begin
        rf_ready[dispatch_dest] <= 1'b0;
      end
    end
  end

  // loads never enter the queue
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= dispatch_valid && (dispatch_cmd != CMD_LOAD);
    end
  end

  always_ff @(posedge clk) begin
    if (dispatch_valid) begin
      fetch_cmd       <= dispatch_cmd;
      fetch_op1       <= src1_data;
      fetch_op2       <= src2_data;
      fetch_op1_valid <= src1_valid;
      fetch_op2_valid <= src2_valid;
      fetch_dest      <= dispatch_dest;
    end
  end

endmodule

`default_nettype wire

// File: sim/ooo_issue_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_issue_properties #(
  parameter int IQ_SIZE = core_types_pkg::IQ_SIZE
) (
  input logic                    clk,
  input logic                    rst,
  input logic                    fetch_valid,
  input logic                    full,
  input logic                    issue_valid,
  input core_types_pkg::iq_idx_t sel_idx,
  input logic [IQ_SIZE-1:0]      entry_valid,
  input logic                    alu_wb_valid
);
  import core_types_pkg::*;

  int fail_count = 0;

  // a non-load dispatch shows up in the fetch register one cycle later
  no_dispatch_when_full: assert property (
    @(posedge clk) disable iff (rst) full |=> !fetch_valid
  ) else begin
    fail_count = fail_count + 1;
    $error("non-load dispatch accepted while the queue was full");
  end

  issue_from_valid_entry: assert property (
    @(posedge clk) disable iff (rst) issue_valid |-> entry_valid[sel_idx]
  ) else begin
    fail_count = fail_count + 1;
    $error("issue selected an empty slot");
  end

  // alu_wb_valid is the result bus looped back
  result_after_issue: assert property (
    @(posedge clk) disable iff (rst) issue_valid |=> alu_wb_valid
  ) else begin
    fail_count = fail_count + 1;
    $error("no result one cycle after issue");
  end

  no_result_without_issue: assert property (
    @(posedge clk) disable iff (rst) alu_wb_valid |-> $past(issue_valid)
  ) else begin
    fail_count = fail_count + 1;
    $error("result without an issue in the previous cycle");
  end

endmodule

bind issue_queue ooo_issue_properties #(
  .IQ_SIZE(IQ_SIZE)
) u_props (
  .clk         (clk),
  .rst         (rst),
  .fetch_valid (fetch_valid),
  .full        (full),
  .issue_valid (issue_valid),
  .sel_idx     (sel_idx),
  .entry_valid (entry_valid),
  .alu_wb_valid(alu_wb_valid)
);

`default_nettype wire

// File: sim/tb_ooo_issue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_issue;
  import core_types_pkg::*;
  import alu_ops_pkg::*;

  typedef struct packed {
    logic     is_mem;
    alu_cmd_t cmd;
    preg_t    src1;
    preg_t    src2;
    data_t    imm;
    logic     use_imm;
    preg_t    dest;
    data_t    expected;
  } row_t;

  // groups woken together by one memory return
  // the first one spans the age wrap
  localparam int WRAP_GROUP_FIRST = 22;
  localparam int WRAP_GROUP_LEN   = 8;
  localparam int GROUP_FIRST      = 31;
  localparam int GROUP_LEN        = 4;

  logic     clk = 1'b0;
  logic     rst;
  logic     dispatch_valid;
  alu_cmd_t dispatch_cmd;
  preg_t    dispatch_src1;
  preg_t    dispatch_src2;
  data_t    dispatch_imm;
  logic     dispatch_use_imm;
  preg_t    dispatch_dest;
  logic     mem_result_valid;
  preg_t    mem_result_tag;
  data_t    mem_result_data;
  logic     full;
  logic     result_valid;
  preg_t    result_tag;
  data_t    result_data;

  row_t                  rows [$];
  data_t                 ref_val [PREG_COUNT];
  logic [PREG_COUNT-1:0] exp_pending;
  // registers whose value the model already knows
  logic [PREG_COUNT-1:0] avail;
  int                    row_of [PREG_COUNT];
  int                    res_cycle [PREG_COUNT];
  int                    n_expected = 0;
  int                    n_seen = 0;
  int                    cycle = 0;
  int                    cycle_limit;
  logic                  started = 1'b0;
  logic                  full_seen = 1'b0;

  ooo_issue_top u_dut (
    .clk             (clk),
    .rst             (rst),
    .dispatch_valid  (dispatch_valid),
    .dispatch_cmd    (dispatch_cmd),
    .dispatch_src1   (dispatch_src1),
    .dispatch_src2   (dispatch_src2),
    .dispatch_imm    (dispatch_imm),
    .dispatch_use_imm(dispatch_use_imm),
    .dispatch_dest   (dispatch_dest),
    .mem_result_valid(mem_result_valid),
    .mem_result_tag  (mem_result_tag),
    .mem_result_data (mem_result_data),
    .full            (full),
    .result_valid    (result_valid),
    .result_tag      (result_tag),
    .result_data     (result_data)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle > cycle_limit) begin
      $display("timeout after %0d cycles, %0d of %0d results seen", cycle, n_seen, n_expected);
      $display("Verification failed");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_value(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "mismatch");
    end
  endtask

  function automatic data_t expected_result(input alu_cmd_t cmd, input data_t a, input data_t b);
    data_t res;
    case (cmd)
      CMD_ADD: res = a + b;
      CMD_SUB: res = a - b;
      CMD_AND: res = a & b;
      CMD_OR:  res = a | b;
      CMD_XOR: res = a ^ b;
      CMD_SLL: res = a << b[4:0];
      CMD_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: res = '0;
    endcase
    return res;
  endfunction

  function automatic row_t op_row(input alu_cmd_t cmd, input int src1, input int src2,
                                  input data_t imm, input logic use_imm, input int dest);
    row_t r;
    r         = '0;
    r.cmd     = cmd;
    r.src1    = preg_t'(src1);
    r.src2    = preg_t'(src2);
    r.imm     = imm;
    r.use_imm = use_imm;
    r.dest    = preg_t'(dest);
    return r;
  endfunction

  function automatic row_t mem_row(input int tag, input data_t data);
    row_t r;
    r        = '0;
    r.is_mem = 1'b1;
    r.dest   = preg_t'(tag);
    r.imm    = data;
    return r;
  endfunction

  function automatic logic is_queued(input row_t r);
    return !r.is_mem && r.cmd != CMD_LOAD;
  endfunction

  // one result per cycle in dispatch order
  task automatic check_wake_order(input int first, input int len);
    for (int g = 0; g < len - 1; g++) begin
      check_value($sformatf("p%0d issues the cycle after p%0d", first + g + 1, first + g),
                  res_cycle[first + g + 1], res_cycle[first + g] + 1);
    end
  endtask

  task automatic build_table();
    // every command with an immediate
    rows.push_back(op_row(CMD_ADD, 0, 0, 32'h1234_5678, 1'b1, 1));
    rows.push_back(op_row(CMD_SUB, 1, 0, 32'h0000_0679, 1'b1, 2));
    rows.push_back(op_row(CMD_AND, 1, 0, 32'h0f0f_0f0f, 1'b1, 3));
    rows.push_back(op_row(CMD_OR,  1, 0, 32'h8000_0001, 1'b1, 4));
    rows.push_back(op_row(CMD_XOR, 1, 0, 32'hffff_0000, 1'b1, 5));
    rows.push_back(op_row(CMD_SLL, 1, 0, 32'h0000_0024, 1'b1, 6));
    rows.push_back(op_row(CMD_SLT, 1, 0, 32'h8000_0000, 1'b1, 7));
    rows.push_back(op_row(CMD_SLT, 5, 1, '0, 1'b0, 8));
    // dependency chain through the alu broadcast
    rows.push_back(op_row(CMD_ADD, 2, 3, '0, 1'b0, 9));
    rows.push_back(op_row(CMD_SUB, 9, 4, '0, 1'b0, 10));
    rows.push_back(op_row(CMD_XOR, 10, 9, '0, 1'b0, 11));
    rows.push_back(op_row(CMD_SLL, 11, 0, 32'd3, 1'b1, 12));
    rows.push_back(op_row(CMD_OR,  12, 10, '0, 1'b0, 13));
    // eight ops on two pending loads fill the queue
    rows.push_back(op_row(CMD_LOAD, 0, 0, '0, 1'b0, 20));
    rows.push_back(op_row(CMD_LOAD, 0, 0, '0, 1'b0, 21));
    rows.push_back(op_row(CMD_ADD, 20, 21, '0, 1'b0, 22));
    rows.push_back(op_row(CMD_SUB, 20, 21, '0, 1'b0, 23));
    rows.push_back(op_row(CMD_AND, 20, 21, '0, 1'b0, 24));
    rows.push_back(op_row(CMD_OR,  20, 21, '0, 1'b0, 25));
    rows.push_back(op_row(CMD_XOR, 20, 21, '0, 1'b0, 26));
    rows.push_back(op_row(CMD_SLL, 20, 21, '0, 1'b0, 27));
    rows.push_back(op_row(CMD_SLT, 20, 21, '0, 1'b0, 28));
    rows.push_back(op_row(CMD_SLT, 21, 20, '0, 1'b0, 29));
    rows.push_back(mem_row(20, 32'hdead_beef));
    rows.push_back(mem_row(21, 32'h0000_0105));
    // one return wakes the whole group
    rows.push_back(op_row(CMD_LOAD, 0, 0, '0, 1'b0, 30));
    rows.push_back(op_row(CMD_ADD, 30, 0, 32'd1, 1'b1, 31));
    rows.push_back(op_row(CMD_SUB, 30, 13, '0, 1'b0, 32));
    rows.push_back(op_row(CMD_XOR, 30, 29, '0, 1'b0, 33));
    rows.push_back(op_row(CMD_SLT, 30, 0, '0, 1'b0, 34));
    rows.push_back(mem_row(30, 32'hf000_0010));
    rows.push_back(op_row(CMD_ADD, 34, 31, '0, 1'b0, 35));
  endtask

  // program order model with load values taken from the memory rows
  task automatic compute_expected();
    data_t b;
    foreach (ref_val[i]) begin
      ref_val[i] = '0;
    end
    foreach (rows[r]) begin
      if (rows[r].is_mem) begin
        ref_val[rows[r].dest] = rows[r].imm;
      end
    end
    foreach (rows[r]) begin
      if (is_queued(rows[r])) begin
        b = rows[r].use_imm ? rows[r].imm : ref_val[rows[r].src2];
        ref_val[rows[r].dest] = expected_result(rows[r].cmd, ref_val[rows[r].src1], b);
        rows[r].expected      = ref_val[rows[r].dest];
        row_of[rows[r].dest]  = r;
        n_expected++;
      end
    end
  endtask

  // dispatch only follows an idle cycle, so full there holds for the next one
  task automatic apply_row(input row_t row);
    @(negedge clk);
    while (is_queued(row) && full) begin
      @(negedge clk);
    end
    @(posedge clk);
    started = 1'b1;
    if (row.is_mem) begin
      mem_result_valid <= 1'b1;
      mem_result_tag   <= row.dest;
      mem_result_data  <= row.imm;
      avail[row.dest]  = 1'b1;
    end else begin
      dispatch_valid   <= 1'b1;
      dispatch_cmd     <= row.cmd;
      dispatch_src1    <= row.src1;
      dispatch_src2    <= row.src2;
      dispatch_imm     <= row.imm;
      dispatch_use_imm <= row.use_imm;
      dispatch_dest    <= row.dest;
      avail[row.dest]  = 1'b0;
      if (is_queued(row)) begin
        exp_pending[row.dest] = 1'b1;
      end
    end
    @(posedge clk);
    dispatch_valid   <= 1'b0;
    mem_result_valid <= 1'b0;
  endtask

  always @(negedge clk) begin : monitor
    int r;
    check_value("bound assertion failures", u_dut.u_iq.u_props.fail_count, 32'd0);
    if (!rst && full === 1'b1) begin
      full_seen = 1'b1;
    end
    if (cycle >= 1 && !started) begin
      check_value("result_valid before first dispatch", result_valid, 32'd0);
      check_value("full before first dispatch", full, 32'd0);
    end
    if (!rst && result_valid) begin
      check_value("result tag is outstanding", exp_pending[result_tag], 32'd1);
      r = row_of[result_tag];
      check_value("source 1 ready before result", avail[rows[r].src1], 32'd1);
      if (!rows[r].use_imm) begin
        check_value("source 2 ready before result", avail[rows[r].src2], 32'd1);
      end
      check_value($sformatf("result data of p%0d", result_tag), result_data, rows[r].expected);
      exp_pending[result_tag] = 1'b0;
      avail[result_tag]       = 1'b1;
      res_cycle[result_tag]   = cycle;
      n_seen++;
    end
  end

  initial begin
    int gap;
    void'($urandom(32'h6a32a079));
    rst              = 1'b1;
    dispatch_valid   = 1'b0;
    dispatch_cmd     = CMD_ADD;
    dispatch_src1    = '0;
    dispatch_src2    = '0;
    dispatch_imm     = '0;
    dispatch_use_imm = 1'b0;
    dispatch_dest    = '0;
    mem_result_valid = 1'b0;
    mem_result_tag   = '0;
    mem_result_data  = '0;
    avail            = '1;
    exp_pending      = '0;
    build_table();
    compute_expected();
    cycle_limit = 40 * rows.size() + 16;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    foreach (rows[i]) begin
      apply_row(rows[i]);
      gap = $urandom % 3;
      repeat (gap) @(posedge clk);
    end
    while (n_seen < n_expected) begin
      @(posedge clk);
    end
    @(negedge clk);
    check_value("queue reached full", full_seen, 32'd1);
    check_value("full after drain", full, 32'd0);
    check_wake_order(WRAP_GROUP_FIRST, WRAP_GROUP_LEN);
    check_wake_order(GROUP_FIRST, GROUP_LEN);
    check_value("bound assertion failures", u_dut.u_iq.u_props.fail_count, 32'd0);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
